//--- cache_mem.f
cache_mem_pkg.sv
cache_ram_1rw.sv
cache_write_ctrl.sv
cache_tag_array.sv
cache_data_array.sv
cache_out_stage.sv
cache_mem_top.sv
tb_clk_gen.sv
tb_cache_mem.sv

//--- Makefile
# Verilator build and run of the cache_mem testbench

VERILATOR ?= verilator
TOP       ?= tb_cache_mem
FILELIST  ?= cache_mem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
FAIL_MSG  ?= *** TEST FAILED ***

SHELL := /bin/bash

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_cache_mem.sv
`timescale 1ns/1ps

module tb_cache_mem;

  localparam int unsigned RST_WAIT    = 20;     // cycles allowed for reset release
  localparam int unsigned WATCHDOG_NS = 20000;

  // one table row, one clock cycle
  typedef struct packed {
    logic [2:0]                 test;       // test number, from 1
    logic                       last;       // closes its test
    logic                       chk_evict;  // victim way valid in the model
    logic                       flush;
    cache_mem_pkg::lookup_req_t lookup;
    cache_mem_pkg::store_req_t  store;
    cache_mem_pkg::fill_req_t   fill;
    cache_mem_pkg::lookup_rsp_t exp;        // response due 2 cycles later
  } step_t;

  logic                       clk;
  logic                       rst_n;
  logic                       flush;
  cache_mem_pkg::lookup_req_t lookup;
  cache_mem_pkg::store_req_t  store;
  cache_mem_pkg::fill_req_t   fill;
  cache_mem_pkg::lookup_rsp_t rsp;

  step_t  steps [$];
  string  test_name [6];
  int     cur_test;
  int     test_errs;
  int     test_lookups;
  int     total_errs;
  int     total_lookups;
  int     failed_tests;
  integer seed;

  // expected cache contents
  cache_mem_pkg::tag_t  m_tag   [cache_mem_pkg::WAYS][cache_mem_pkg::SETS];
  logic                 m_valid [cache_mem_pkg::WAYS][cache_mem_pkg::SETS];
  logic                 m_dirty [cache_mem_pkg::WAYS][cache_mem_pkg::SETS];
  cache_mem_pkg::line_t m_line  [cache_mem_pkg::WAYS][cache_mem_pkg::SETS];

  tb_clk_gen u_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  cache_mem_top dut_i (
    .clk_i    ( clk    ),
    .rst_ni   ( rst_n  ),
    .flush_i  ( flush  ),
    .lookup_i ( lookup ),
    .store_i  ( store  ),
    .fill_i   ( fill   ),
    .rsp_o    ( rsp    )
  );

  ////////////////////
  // stimulus helpers
  ////////////////////

  // line pattern from set and way
  function automatic cache_mem_pkg::line_t line_of(input int set, input int way);
    cache_mem_pkg::word_t w;
    w = {4'hC, 1'b0, cache_mem_pkg::idx_t'(set), 7'h00, cache_mem_pkg::way_num_t'(way),
         4'hA, 1'b0, cache_mem_pkg::idx_t'(set), 7'h00, cache_mem_pkg::way_num_t'(way)};
    return {w ^ 32'h5A5A_0F0F, w};  // upper word differs from lower
  endfunction

  function automatic cache_mem_pkg::tag_t tag_of(input int set, input int way);
    return {cache_mem_pkg::idx_t'(set), cache_mem_pkg::way_num_t'(way), 22'h2A5F3C};
  endfunction

  function automatic cache_mem_pkg::tag_t random_tag();
    logic [31:0] r;
    r = $random(seed);
    return r[cache_mem_pkg::TAG_BITS-1:0];
  endfunction

  function automatic cache_mem_pkg::lookup_req_t lookup_req(input int set,
                                                            input cache_mem_pkg::tag_t tag,
                                                            input int victim);
    cache_mem_pkg::lookup_req_t r;
    r.valid  = 1'b1;
    r.idx    = cache_mem_pkg::idx_t'(set);
    r.tag    = tag;
    r.victim = cache_mem_pkg::way_num_t'(victim);
    return r;
  endfunction

  function automatic cache_mem_pkg::store_req_t store_req(input int set,
                                                          input cache_mem_pkg::line_be_t be,
                                                          input cache_mem_pkg::word_t data,
                                                          input cache_mem_pkg::ways_t ways);
    cache_mem_pkg::store_req_t r;
    r.we       = 1'b1;
    r.idx      = cache_mem_pkg::idx_t'(set);
    r.be       = be;
    r.data     = data;
    r.ways_hit = ways;
    return r;
  endfunction

  // filling and ack in the same cycle, line written at once
  function automatic cache_mem_pkg::fill_req_t fill_req(input int set, input int way,
                                                        input logic dirty);
    cache_mem_pkg::fill_req_t r;
    r.filling = 1'b1;
    r.ack     = 1'b1;
    r.dirty   = dirty;
    r.idx     = cache_mem_pkg::idx_t'(set);
    r.tag     = tag_of(set, way);
    r.way     = cache_mem_pkg::ways_t'(1 << way);  // one-hot
    r.line    = line_of(set, way);
    return r;
  endfunction

  ////////////////////
  // table and model
  ////////////////////

  // expected response from the contents before this cycle's writes
  task automatic push_step(input cache_mem_pkg::lookup_req_t lk,
                           input cache_mem_pkg::store_req_t st,
                           input cache_mem_pkg::fill_req_t fl, input logic fsh);
    step_t s;
    logic  fill_we;
    logic  store_acc;
    s = '0;
    s.test      = 3'(cur_test);
    s.lookup    = lk;
    s.store     = st;
    s.fill      = fl;
    s.flush     = fsh;
    fill_we     = fl.filling & fl.ack;
    store_acc   = st.we & ~fill_we & ~lk.valid;  // store only on an idle port
    s.exp.valid = lk.valid & ~fill_we;
    if (s.exp.valid)
    begin
      for (int w = 0; w < cache_mem_pkg::WAYS; w++)
      begin
        s.exp.ways_hit[w]   = m_valid[w][lk.idx] && (m_tag[w][lk.idx] == lk.tag);
        s.exp.ways_dirty[w] = m_valid[w][lk.idx] && m_dirty[w][lk.idx];
        if (s.exp.ways_hit[w]) s.exp.line = m_line[w][lk.idx];
      end
      s.exp.hit        = |s.exp.ways_hit;
      s.exp.dirty      = |s.exp.ways_dirty;
      s.exp.way_dirty  = s.exp.ways_dirty[lk.victim];
      s.exp.evict_tag  = m_tag[lk.victim][lk.idx];
      s.exp.evict_line = m_line[lk.victim][lk.idx];
      s.chk_evict      = m_valid[lk.victim][lk.idx];  // ram unknown before first fill
    end
    for (int w = 0; w < cache_mem_pkg::WAYS; w++)
    begin
      if (fill_we && fl.way[w])
      begin
        m_tag[w][fl.idx]   = fl.tag;
        m_valid[w][fl.idx] = 1'b1;
        m_dirty[w][fl.idx] = fl.dirty;
        m_line[w][fl.idx]  = fl.line;
      end
      if (store_acc && st.ways_hit[w])
      begin
        for (int b = 0; b < cache_mem_pkg::BLK_BYTES; b++)
        begin
          if (st.be[b]) m_line[w][st.idx][8*b +: 8] = st.data[8*(b % 4) +: 8];
        end
        m_dirty[w][st.idx] = 1'b1;
      end
      for (int i = 0; i < cache_mem_pkg::SETS; i++)
      begin
        if (fsh) m_valid[w][i] = 1'b0;  // dirty survives a flush
      end
    end
    steps.push_back(s);
  endtask

  task automatic push_idle();
    push_step('0, '0, '0, 1'b0);
  endtask

  // two idle cycles drain the last response of a test
  task automatic close_test();
    push_idle();
    push_idle();
    steps[steps.size()-1].last = 1'b1;
    cur_test++;
  endtask

  task automatic build_table();
    for (int w = 0; w < cache_mem_pkg::WAYS; w++)
    begin
      for (int i = 0; i < cache_mem_pkg::SETS; i++)
      begin
        m_tag[w][i]   = '0;
        m_valid[w][i] = 1'b0;
        m_dirty[w][i] = 1'b0;
        m_line[w][i]  = '0;
      end
    end
    cur_test = 1;
    test_name[0] = "reset and miss";
    for (int s = 0; s < cache_mem_pkg::SETS; s++)
      push_step(lookup_req(s, random_tag(), 0), '0, '0, 1'b0);
    close_test();
    test_name[1] = "fill then hit";
    push_step('0, '0, fill_req(3, 0, 1'b0), 1'b0);  // clean way 0
    push_step('0, '0, fill_req(3, 1, 1'b1), 1'b0);  // dirty way 1
    push_idle();
    push_step(lookup_req(3, tag_of(3, 0), 0), '0, '0, 1'b0);
    push_step(lookup_req(3, tag_of(3, 1), 0), '0, '0, 1'b0);
    push_step(lookup_req(3, random_tag(), 0), '0, '0, 1'b0);
    close_test();
    test_name[2] = "store";
    push_step('0, store_req(3, 8'b0000_0110, 32'hA5C3_9617, 2'b01), '0, 1'b0);
    push_idle();
    push_step(lookup_req(3, tag_of(3, 0), 0), '0, '0, 1'b0);
    // lookup holds the port, store is dropped
    push_step(lookup_req(5, random_tag(), 0),
              store_req(3, 8'b1111_0000, 32'hDEAD_BEEF, 2'b10), '0, 1'b0);
    push_idle();
    push_step(lookup_req(3, tag_of(3, 1), 0), '0, '0, 1'b0);
    close_test();
    test_name[3] = "eviction";
    push_step(lookup_req(3, tag_of(3, 1), 1), '0, '0, 1'b0);  // hit on the victim
    push_step(lookup_req(3, random_tag(), 1), '0, '0, 1'b0);
    push_step(lookup_req(3, random_tag(), 0), '0, '0, 1'b0);  // way 0 dirty by store
    push_step('0, '0, fill_req(6, 1, 1'b1), 1'b0);
    push_idle();
    push_step(lookup_req(6, random_tag(), 1), '0, '0, 1'b0);
    close_test();
    test_name[4] = "flush";
    push_step('0, '0, '0, 1'b1);
    push_idle();
    push_step(lookup_req(3, tag_of(3, 0), 0), '0, '0, 1'b0);
    push_step(lookup_req(3, tag_of(3, 1), 1), '0, '0, 1'b0);
    push_step(lookup_req(6, tag_of(6, 1), 1), '0, '0, 1'b0);
    close_test();
    test_name[5] = "back-to-back";
    push_step('0, '0, fill_req(1, 0, 1'b0), 1'b0);
    push_step('0, '0, fill_req(2, 1, 1'b1), 1'b0);
    push_idle();
    push_step(lookup_req(1, tag_of(1, 0), 0), '0, '0, 1'b0);
    push_step(lookup_req(2, tag_of(2, 1), 1), '0, '0, 1'b0);
    push_step(lookup_req(1, tag_of(1, 0), 1), '0, '0, 1'b0);
    push_step(lookup_req(2, tag_of(2, 1), 0), '0, '0, 1'b0);
    push_step(lookup_req(1, random_tag(), 0), '0, '0, 1'b0);
    close_test();
  endtask

  ////////////////////
  // drive and check
  ////////////////////

  task automatic drive_step(input step_t s);
    lookup = s.lookup;
    store  = s.store;
    fill   = s.fill;
    flush  = s.flush;
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("[ERROR] %t: %s expected %h, actual %h", $time, name, exp, act);
    test_errs++;
  endtask

  task automatic check_step(input int i);
    cache_mem_pkg::lookup_rsp_t e;
    e = steps[i].exp;
    if (rsp.valid !== e.valid) report_mismatch("rsp.valid", 64'(e.valid), 64'(rsp.valid));
    if (e.valid)
    begin
      test_lookups++;
      if (rsp.hit !== e.hit) report_mismatch("rsp.hit", 64'(e.hit), 64'(rsp.hit));
      if (rsp.ways_hit !== e.ways_hit)
        report_mismatch("rsp.ways_hit", 64'(e.ways_hit), 64'(rsp.ways_hit));
      if (rsp.dirty !== e.dirty) report_mismatch("rsp.dirty", 64'(e.dirty), 64'(rsp.dirty));
      if (rsp.ways_dirty !== e.ways_dirty)
        report_mismatch("rsp.ways_dirty", 64'(e.ways_dirty), 64'(rsp.ways_dirty));
      if (rsp.way_dirty !== e.way_dirty)
        report_mismatch("rsp.way_dirty", 64'(e.way_dirty), 64'(rsp.way_dirty));
      if (rsp.line !== e.line) report_mismatch("rsp.line", e.line, rsp.line);
      if (steps[i].chk_evict && rsp.evict_tag !== e.evict_tag)
        report_mismatch("rsp.evict_tag", 64'(e.evict_tag), 64'(rsp.evict_tag));
      if (steps[i].chk_evict && rsp.evict_line !== e.evict_line)
        report_mismatch("rsp.evict_line", e.evict_line, rsp.evict_line);
    end
    if (steps[i].last)
    begin
      $display("test %0d %s, lookups %0d, mismatches %0d", steps[i].test,
               test_name[steps[i].test - 1], test_lookups, test_errs);
      if (test_errs != 0) failed_tests++;
      total_errs    += test_errs;
      total_lookups += test_lookups;
      test_errs     = 0;
      test_lookups  = 0;
    end
  endtask

  ////////////////////
  // main
  ////////////////////

  initial
  begin
    $timeformat(-9, 0, " ns", 0);
    lookup        = '0;
    store         = '0;
    fill          = '0;
    flush         = 1'b0;
    seed          = 32'h4269_e6d1;
    test_errs     = 0;
    test_lookups  = 0;
    total_errs    = 0;
    total_lookups = 0;
    failed_tests  = 0;
    build_table();
    for (int i = 0; i < RST_WAIT && rst_n !== 1'b1; i++) @(posedge clk);
    if (rst_n !== 1'b1)
    begin
      $display("reset was never released");
      $display("*** TEST FAILED ***");
      $finish;
    end
    else
    begin
      // row k driven at falling edge k, its response sampled at falling edge k+2
      for (int k = 0; k < steps.size() + 2; k++)
      begin
        @(negedge clk);
        if (k >= 2) check_step(k - 2);
        else if (rsp.valid !== 1'b0) report_mismatch("rsp.valid", 64'd0, 64'(rsp.valid));
        if (k < steps.size()) drive_step(steps[k]);
        else drive_step('0);
      end
      $display("tests %0d, failed %0d, lookups checked %0d, mismatches %0d",
               cur_test - 1, failed_tests, total_lookups, total_errs);
      if (total_errs == 0 && failed_tests == 0)
        $display("*** TEST PASSED ***");
      else
        $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("simulation ran past its time limit of %0d ns", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 40,
  parameter int unsigned RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no   // active low, released on a falling edge
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial
  begin
    rst_no = 1'b0;
    #(RST_CYCLES * PERIOD_NS) rst_no = 1'b1;  // two full cycles of reset
  end

endmodule

//--- cache_mem_top.sv
`timescale 1ns/1ps

module cache_mem_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,   // one cycle pulse
  input  cache_mem_pkg::lookup_req_t lookup_i,
  input  cache_mem_pkg::store_req_t  store_i,
  input  cache_mem_pkg::fill_req_t   fill_i,
  output cache_mem_pkg::lookup_rsp_t rsp_o      // two cycles after lookup
);

  cache_mem_pkg::idx_t     idx;         // shared ram index
  cache_mem_pkg::ways_t    tag_we;
  cache_mem_pkg::ways_t    dirty_we;
  logic                    dirty;
  cache_mem_pkg::ways_t    dat_we;
  cache_mem_pkg::line_t    dat;
  cache_mem_pkg::line_be_t be;
  logic                    lookup_acc;
  cache_mem_pkg::tag_rd_t  tag_rd;
  cache_mem_pkg::line_t    lines [cache_mem_pkg::WAYS];

  ////////////////////
  // port arbitration
  ////////////////////

  cache_write_ctrl u_write_ctrl (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .lookup_i     ( lookup_i   ),
    .store_i      ( store_i    ),
    .fill_i       ( fill_i     ),
    .idx_o        ( idx        ),
    .tag_we_o     ( tag_we     ),
    .dirty_we_o   ( dirty_we   ),
    .dirty_o      ( dirty      ),
    .dat_we_o     ( dat_we     ),
    .dat_o        ( dat        ),
    .be_o         ( be         ),
    .lookup_acc_o ( lookup_acc )
  );

  ////////////////////
  // storage
  ////////////////////

  cache_tag_array u_tag_array (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .flush_i    ( flush_i    ),
    .idx_i      ( idx        ),
    .tag_i      ( fill_i.tag ),  // only fills write tags
    .tag_we_i   ( tag_we     ),
    .dirty_we_i ( dirty_we   ),
    .dirty_i    ( dirty      ),
    .tag_rd_o   ( tag_rd     )
  );

  cache_data_array u_data_array (
    .clk_i   ( clk_i  ),
    .idx_i   ( idx    ),
    .we_i    ( dat_we ),
    .be_i    ( be     ),
    .dat_i   ( dat    ),
    .lines_o ( lines  )
  );

  ////////////////////
  // response
  ////////////////////

  cache_out_stage u_out_stage (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .lookup_i     ( lookup_i   ),
    .lookup_acc_i ( lookup_acc ),
    .tag_rd_i     ( tag_rd     ),
    .lines_i      ( lines      ),
    .rsp_o        ( rsp_o      )
  );

endmodule

//--- cache_out_stage.sv
`timescale 1ns/1ps

module cache_out_stage (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  cache_mem_pkg::lookup_req_t lookup_i,
  input  logic                       lookup_acc_i,
  input  cache_mem_pkg::tag_rd_t     tag_rd_i,
  input  cache_mem_pkg::line_t       lines_i [cache_mem_pkg::WAYS],
  output cache_mem_pkg::lookup_rsp_t rsp_o
);

  cache_mem_pkg::lookup_req_t lookup_q;   // request aligned with ram output
  logic                       acc_q;
  cache_mem_pkg::ways_t       way_hit;
  cache_mem_pkg::ways_t       way_dirty;  // valid and dirty
  cache_mem_pkg::line_t       line_mux;
  cache_mem_pkg::lookup_rsp_t rsp_d;
  cache_mem_pkg::lookup_rsp_t rsp_q;
  logic                       valid_q;

  ////////////////////
  // request delay
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni) acc_q <= 1'b0;
    else         acc_q <= lookup_acc_i;
  end

  always_ff @(posedge clk_i)
  begin
    lookup_q <= lookup_i;  // idx unused here, tag and victim matter
  end

  ////////////////////
  // compare and mux
  ////////////////////

  always_comb
  begin
    line_mux = '0;
    for (int unsigned w = 0; w < cache_mem_pkg::WAYS; w++)
    begin
      way_hit[w]   = tag_rd_i.valid[w] & (tag_rd_i.tag[w] == lookup_q.tag);
      way_dirty[w] = tag_rd_i.valid[w] & tag_rd_i.dirty[w];
      line_mux     = line_mux | (lines_i[w] & {cache_mem_pkg::BLK_BITS{way_hit[w]}});  // and-or
    end
  end

  always_comb
  begin
    rsp_d.valid      = acc_q;
    rsp_d.hit        = |way_hit;
    rsp_d.ways_hit   = way_hit;
    rsp_d.dirty      = |way_dirty;
    rsp_d.ways_dirty = way_dirty;
    rsp_d.way_dirty  = way_dirty[lookup_q.victim];     // victim way state
    rsp_d.evict_tag  = tag_rd_i.tag[lookup_q.victim];
    rsp_d.evict_line = lines_i[lookup_q.victim];
    rsp_d.line       = line_mux;                       // zero on miss
  end

  ////////////////////
  // response register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni) valid_q <= 1'b0;
    else         valid_q <= rsp_d.valid;
  end

  always_ff @(posedge clk_i)
  begin
    rsp_q <= rsp_d;  // payload only
  end

  always_comb
  begin
    rsp_o       = rsp_q;
    rsp_o.valid = valid_q;
  end

  // fill side picks a free or victim way, never a duplicate tag
  a_hit_onehot0 : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    acc_q |-> $onehot0(way_hit)
  );

endmodule

//--- cache_data_array.sv
`timescale 1ns/1ps

module cache_data_array (
  input  logic                    clk_i,
  input  cache_mem_pkg::idx_t     idx_i,
  input  cache_mem_pkg::ways_t    we_i,     // per way line write
  input  cache_mem_pkg::line_be_t be_i,     // all ones on a fill
  input  cache_mem_pkg::line_t    dat_i,
  output cache_mem_pkg::line_t    lines_o [cache_mem_pkg::WAYS]
);

  ////////////////////
  // data rams
  ////////////////////

  // one line wide ram per way, shared index and data
  for (genvar w = 0; w < cache_mem_pkg::WAYS; w++)
  begin : gen_dat_ram
    cache_ram_1rw #(
      .DBITS  ( cache_mem_pkg::BLK_BITS )
    ) u_dat_ram (
      .clk_i  ( clk_i      ),
      .addr_i ( idx_i      ),
      .we_i   ( we_i[w]    ),  // fill way or store hit way
      .be_i   ( be_i       ),
      .din_i  ( dat_i      ),
      .dout_o ( lines_o[w] )   // valid one cycle after idx
    );
  end

endmodule

//--- cache_tag_array.sv
`timescale 1ns/1ps

module cache_tag_array (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,     // clears every valid bit
  input  cache_mem_pkg::idx_t    idx_i,
  input  cache_mem_pkg::tag_t    tag_i,       // fill tag
  input  cache_mem_pkg::ways_t   tag_we_i,
  input  cache_mem_pkg::ways_t   dirty_we_i,
  input  logic                   dirty_i,
  output cache_mem_pkg::tag_rd_t tag_rd_o
);

  cache_mem_pkg::tag_t                                      tag_q [cache_mem_pkg::WAYS];
  logic [cache_mem_pkg::WAYS-1:0][cache_mem_pkg::SETS-1:0]  valid_q;  // per way, per set
  logic [cache_mem_pkg::WAYS-1:0][cache_mem_pkg::SETS-1:0]  dirty_q;
  cache_mem_pkg::idx_t                                      idx_q;    // matches ram latency

  ////////////////////
  // tag rams
  ////////////////////

  for (genvar w = 0; w < cache_mem_pkg::WAYS; w++)
  begin : gen_tag_ram
    cache_ram_1rw #(
      .DBITS  ( cache_mem_pkg::TAG_BITS )
    ) u_tag_ram (
      .clk_i  ( clk_i                                ),
      .addr_i ( idx_i                                ),
      .we_i   ( tag_we_i[w]                          ),
      .be_i   ( {((cache_mem_pkg::TAG_BITS+7)/8){1'b1}} ),
      .din_i  ( tag_i                                ),
      .dout_o ( tag_q[w]                             )
    );
  end

  ////////////////////
  // valid and dirty
  ////////////////////

  // flip-flops so a flush clears all sets at once
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      valid_q <= '0;
    else if (flush_i)
      valid_q <= '0;  // wins over a fill in the same cycle
    else
    begin
      for (int unsigned w = 0; w < cache_mem_pkg::WAYS; w++)
      begin
        if (tag_we_i[w]) valid_q[w][idx_i] <= 1'b1;
      end
    end
  end

  // kept across a flush, masked by valid
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      dirty_q <= '0;
    else
    begin
      for (int unsigned w = 0; w < cache_mem_pkg::WAYS; w++)
      begin
        if (dirty_we_i[w]) dirty_q[w][idx_i] <= dirty_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni) idx_q <= '0;
    else         idx_q <= idx_i;
  end

  ////////////////////
  // read port
  ////////////////////

  always_comb
  begin
    for (int unsigned w = 0; w < cache_mem_pkg::WAYS; w++)
    begin
      tag_rd_o.tag[w]   = tag_q[w];
      tag_rd_o.valid[w] = valid_q[w][idx_q];  // registered index
      tag_rd_o.dirty[w] = dirty_q[w][idx_q];
    end
  end

endmodule

//--- cache_write_ctrl.sv
`timescale 1ns/1ps

module cache_write_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  cache_mem_pkg::lookup_req_t lookup_i,
  input  cache_mem_pkg::store_req_t  store_i,
  input  cache_mem_pkg::fill_req_t   fill_i,
  output cache_mem_pkg::idx_t        idx_o,        // shared ram index
  output cache_mem_pkg::ways_t       tag_we_o,
  output cache_mem_pkg::ways_t       dirty_we_o,
  output logic                       dirty_o,
  output cache_mem_pkg::ways_t       dat_we_o,
  output cache_mem_pkg::line_t       dat_o,
  output cache_mem_pkg::line_be_t    be_o,
  output logic                       lookup_acc_o
);

  logic                 fill_we;    // line write from the bus unit
  logic                 store_acc;  // write buffer gets the port
  cache_mem_pkg::ways_t store_we;   // hit ways of an accepted store

  ////////////////////
  // arbitration
  ////////////////////

  assign fill_we      = fill_i.filling & fill_i.ack;
  assign store_acc    = store_i.we & ~fill_we & ~lookup_i.valid;  // lowest priority
  assign lookup_acc_o = lookup_i.valid & ~fill_we;

  always_comb
  begin
    if (fill_we)        idx_o = fill_i.idx;
    else if (store_acc) idx_o = store_i.idx;
    else                idx_o = lookup_i.idx;  // default read index
  end

  ////////////////////
  // enables and data
  ////////////////////

  assign store_we   = {cache_mem_pkg::WAYS{store_acc}} & store_i.ways_hit;
  assign tag_we_o   = {cache_mem_pkg::WAYS{fill_we}} & fill_i.way;  // tag and valid
  assign dirty_we_o = tag_we_o | store_we;
  assign dat_we_o   = tag_we_o | store_we;

  // store always leaves the line dirty
  assign dirty_o = fill_we ? fill_i.dirty : 1'b1;

  // word copied into every word slot, be picks the right one
  assign dat_o = fill_we ? fill_i.line
                         : {(cache_mem_pkg::BLK_BITS / cache_mem_pkg::XLEN){store_i.data}};
  assign be_o  = fill_we ? '1 : store_i.be;

  ////////////////////
  // checks
  ////////////////////

  a_fill_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fill_i.filling |-> $onehot(fill_i.way)
  );

  // no store gets the port during a fill write
  a_fill_excl : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fill_we |-> !store_acc
  );

endmodule

//--- cache_ram_1rw.sv
`timescale 1ns/1ps

module cache_ram_1rw #(
  parameter int unsigned DBITS = 32  // word width of the array
) (
  input  logic                     clk_i,
  input  cache_mem_pkg::idx_t      addr_i,
  input  logic                     we_i,
  input  logic [(DBITS+7)/8-1:0]   be_i,   // last byte may be partial
  input  logic [DBITS-1:0]         din_i,
  output logic [DBITS-1:0]         dout_o
);

  logic [DBITS-1:0] mem [cache_mem_pkg::SETS];  // one word per set

  ////////////////////
  // write port
  ////////////////////

  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      for (int unsigned b = 0; b < DBITS; b++)
      begin
        if (be_i[b/8]) mem[addr_i][b] <= din_i[b];  // byte lane select
      end
    end
  end

  ////////////////////
  // read port
  ////////////////////

  // read before write, old data on a same address write
  always_ff @(posedge clk_i)
  begin
    dout_o <= mem[addr_i];
  end

endmodule

//--- cache_mem_pkg.sv
package cache_mem_pkg;

  ////////////////////
  // geometry
  ////////////////////

  localparam int unsigned XLEN      = 32;                           // core word width
  localparam int unsigned WAYS      = 2;
  localparam int unsigned SETS      = 8;
  localparam int unsigned BLK_BITS  = 64;                           // one cache line
  localparam int unsigned IDX_BITS  = $clog2(SETS);                 // 3
  localparam int unsigned OFFS_BITS = $clog2(BLK_BITS / 8);         // byte offset in line
  localparam int unsigned TAG_BITS  = XLEN - IDX_BITS - OFFS_BITS;  // 26
  localparam int unsigned BLK_BYTES = BLK_BITS / 8;

  ////////////////////
  // vector types
  ////////////////////

  typedef logic [XLEN-1:0]          word_t;
  typedef logic [BLK_BITS-1:0]      line_t;
  typedef logic [BLK_BYTES-1:0]     line_be_t;  // byte enables over a full line
  typedef logic [IDX_BITS-1:0]      idx_t;
  typedef logic [TAG_BITS-1:0]      tag_t;
  typedef logic [WAYS-1:0]          ways_t;     // one bit per way
  typedef logic [$clog2(WAYS)-1:0]  way_num_t;  // binary way number

  ////////////////////
  // requests
  ////////////////////

  typedef struct packed {
    logic     valid;
    idx_t     idx;
    tag_t     tag;     // delayed inside the block
    way_num_t victim;  // way reported for eviction
  } lookup_req_t;

  // write buffer side
  typedef struct packed {
    logic     we;
    idx_t     idx;
    line_be_t be;        // already word aligned
    word_t    data;
    ways_t    ways_hit;
  } store_req_t;

  // bus interface unit side, held stable until ack
  typedef struct packed {
    logic  filling;
    logic  ack;
    logic  dirty;  // dirty flag written with the line
    idx_t  idx;
    tag_t  tag;
    ways_t way;    // one-hot
    line_t line;
  } fill_req_t;

  ////////////////////
  // responses
  ////////////////////

  typedef struct packed {
    logic  valid;
    logic  hit;
    ways_t ways_hit;
    logic  dirty;       // any way valid and dirty
    ways_t ways_dirty;
    logic  way_dirty;   // victim way valid and dirty
    tag_t  evict_tag;
    line_t evict_line;
    line_t line;        // hit way line, zero on miss
  } lookup_rsp_t;

  // tag array read port, aligned with the ram output
  typedef struct packed {
    tag_t [WAYS-1:0] tag;
    ways_t           valid;
    ways_t           dirty;
  } tag_rd_t;

endpackage
